//--- int_core.f
logic/rv_int_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/exec_int.sv
logic/int_core.sv
verification/int_core_tb.sv

//--- Makefile
# Verilator build and run for the integer execute slice

VERILATOR ?= verilator
TOP       ?= int_core_tb
FILELIST  ?= int_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/int_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_core_tb import rv_int_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;   // Roughly four times the whole stimulus

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
    } pending_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     i_valid;
    instr_t   i_instr;
    addr_t    i_pc;
    logic     o_valid;
    logic     o_exception;
    reg_idx_t o_rd;
    xlen_t    o_result;

    integer   seed;
    int       cycle_count;
    int       fail_count;
    int       tests_passed;
    int       tests_failed;
    int       test_start_fails;
    xlen_t    model_regs [32];   // Architectural state in program order
    pending_t pending_q [$];
    pending_t chk_item;
    logic     chk_exc;
    xlen_t    chk_res;

    int_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_instr     (i_instr),
        .i_pc        (i_pc),
        .o_valid     (o_valid),
        .o_exception (o_exception),
        .o_rd        (o_rd),
        .o_result    (o_result)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic instr_t encode_u(logic [4:0] op, reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, op, 2'b11};
    endfunction

    function automatic instr_t encode_op_imm(reg_idx_t rd, logic [2:0] f3, reg_idx_t rs1,
                                             logic [11:0] imm);
        return {imm, rs1, f3, rd, 5'b00100, 2'b11};
    endfunction

    // Random legal OP-IMM with clean upper bits on shifts
    function automatic instr_t random_op_imm(reg_idx_t rd, reg_idx_t rs1);
        logic [31:0] r;
        logic [11:0] imm;
        r   = rand32();
        imm = r[31:20];
        if (r[2:0] == 3'b001) begin
            imm[11:6] = 6'b0;
        end else if (r[2:0] == 3'b101) begin
            imm[11]  = 1'b0;   // Bit 10 still picks SRAI
            imm[9:6] = 4'b0;
        end
        return encode_op_imm(rd, r[2:0], rs1, imm);
    endfunction

    function automatic reg_idx_t random_reg();
        logic [31:0] r;
        r = rand32();
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];   // Never x0
    endfunction

    function automatic addr_t random_pc();
        addr_t p;
        p      = {rand32(), rand32()};
        p[1:0] = 2'b00;
        return p;
    endfunction

    // Expected outcome from the ISA rules against the model registers
    task automatic predict(input instr_t w, input addr_t pc, output logic exc,
                           output xlen_t res);
        xlen_t      a;
        xlen_t      u_val;
        xlen_t      i_val;
        logic [5:0] sh;
        a     = model_regs[w[19:15]];
        u_val = {{32{w[31]}}, w[31:12], 12'h000};
        i_val = {{52{w[31]}}, w[31:20]};
        sh    = w[25:20];
        exc   = 1'b0;
        res   = '0;
        case (w[6:2])
            5'b01101: res = u_val;        // LUI
            5'b00101: res = pc + u_val;   // AUIPC
            5'b00100: begin
                case (w[14:12])
                    3'b000: res = a + i_val;
                    3'b010: res = ($signed(a) < $signed(i_val)) ? 64'd1 : 64'd0;
                    3'b011: res = (a < i_val) ? 64'd1 : 64'd0;
                    3'b100: res = a ^ i_val;
                    3'b110: res = a | i_val;
                    3'b111: res = a & i_val;
                    3'b001: begin
                        exc = w[31:26] != 6'b0;
                        res = a << sh;
                    end
                    default: begin
                        exc = w[31] || w[29:26] != 4'b0;
                        if (w[30]) begin
                            res = $signed(a) >>> sh;
                        end else begin
                            res = a >> sh;
                        end
                    end
                endcase
            end
            default: exc = 1'b1;
        endcase
    endtask

    task automatic issue(input instr_t w, input addr_t pc);
        pending_t item;
        item.instr = w;
        item.pc    = pc;
        @(posedge clk);
        i_valid <= 1'b1;
        i_instr <= w;
        i_pc    <= pc;
        pending_q.push_back(item);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            i_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (pending_q.size() != 0) begin
            idle(1);
        end
        idle(2);
    endtask

    task automatic start_test();
        test_start_fails = fail_count;
    endtask

    task automatic end_test(input string name);
        drain();
        if (fail_count == test_start_fails) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, fail_count - test_start_fails);
        end
    endtask

    // Latency rule
    assert property (@(posedge clk) disable iff (rst) o_valid == $past(i_valid, 2))
        else begin
            $display("Fail at %0t: o_valid differs from i_valid two cycles earlier", $time);
            fail_count++;
        end

    // Response checks away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            assert (o_valid === 1'b0) else begin
                $display("Fail at %0t: o_valid not low during reset", $time);
                fail_count++;
            end
        end else if (o_valid) begin
            assert (pending_q.size() != 0) else begin
                $display("Unexpected o_valid at %0t with no instruction in flight", $time);
                fail_count++;
            end
            if (pending_q.size() != 0) begin
                chk_item = pending_q.pop_front();
                predict(chk_item.instr, chk_item.pc, chk_exc, chk_res);
                assert (o_exception == chk_exc) else begin
                    $display("Fail at %0t: exception %0b, expected %0b for instr %h",
                             $time, o_exception, chk_exc, chk_item.instr);
                    fail_count++;
                end
                assert (o_rd == chk_item.instr[11:7]) else begin
                    $display("Fail at %0t: rd %0d, expected %0d", $time, o_rd,
                             chk_item.instr[11:7]);
                    fail_count++;
                end
                if (!chk_exc) begin
                    assert (o_result == chk_res) else begin
                        $display("Fail at %0t: result %h, expected %h for instr %h",
                                 $time, o_result, chk_res, chk_item.instr);
                        fail_count++;
                    end
                    if (chk_item.instr[11:7] != 5'd0) begin
                        model_regs[chk_item.instr[11:7]] = chk_res;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d instructions in flight",
                     cycle_count, pending_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [11:0] imm;
        logic [4:0]  op;
        reg_idx_t    rd;
        reg_idx_t    prev;
        rst          = 1'b1;
        i_valid      = 1'b0;
        i_instr      = '0;
        i_pc         = '0;
        seed         = 49;
        cycle_count  = 0;
        fail_count   = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        start_test();
        idle(8);   // Nothing may come out while idle
        for (int k = 0; k < 3; k++) begin
            issue(random_op_imm(random_reg(), random_reg()), random_pc());
            idle(3);
        end
        issue(encode_u(5'b01101, 5'd2, 20'h12345), random_pc());
        issue(encode_u(5'b00101, 5'd3, 20'hfedcb), random_pc());
        end_test("reset and latency");

        start_test();
        for (int k = 0; k < 40; k++) begin
            r  = rand32();
            op = r[0] ? 5'b01101 : 5'b00101;
            issue(encode_u(op, random_reg(), (k % 4 == 0) ? (r[31:12] | 20'h80000) : r[31:12]),
                  random_pc());
            if (r[1]) begin
                idle(1);
            end
        end
        end_test("LUI and AUIPC");

        start_test();
        for (int k = 1; k < 32; k++) begin
            r = rand32();
            issue(encode_u(5'b01101, k[4:0], r[31:12]), random_pc());
        end
        for (int k = 0; k < 200; k++) begin
            r = rand32();
            issue(random_op_imm(r[4:0], r[9:5]), random_pc());
        end
        end_test("OP-IMM arithmetic and logic");

        start_test();
        for (int c = 0; c < 4; c++) begin
            prev = random_reg();
            for (int k = 0; k < 8; k++) begin
                rd = random_reg();
                issue(random_op_imm(rd, prev), random_pc());   // Reads the producer just issued
                prev = rd;
            end
        end
        end_test("back-to-back dependence");

        start_test();
        for (int k = 0; k < 18; k++) begin
            r   = rand32();
            rd  = random_reg();
            imm = r[31:20];
            case ((k / 3) % 4)
                0: op = 5'b00000;   // LOAD
                1: op = 5'b01100;   // OP
                2: op = 5'b11000;   // BRANCH
                default: op = 5'b11100;   // SYSTEM
            endcase
            if (k % 3 == 0) begin
                issue({r[31:12], rd, op, 2'b11}, random_pc());
            end else if (k % 3 == 1) begin
                if (imm[11:6] == 6'b0) begin
                    imm[11] = 1'b1;
                end
                issue(encode_op_imm(rd, 3'b001, r[19:15], imm), random_pc());
            end else begin
                if (!imm[11] && imm[9:6] == 4'b0) begin
                    imm[7] = 1'b1;
                end
                issue(encode_op_imm(rd, 3'b101, r[19:15], imm), random_pc());
            end
            issue(encode_op_imm(random_reg(), 3'b000, rd, 12'h000), random_pc());
        end
        end_test("exceptions without writeback");

        start_test();
        issue(encode_u(5'b01101, 5'd0, 20'habcde), random_pc());
        issue(encode_op_imm(5'd0, 3'b000, 5'd5, 12'h07b), random_pc());
        issue(encode_op_imm(5'd7, 3'b000, 5'd0, 12'h000), random_pc());
        idle(3);
        issue(encode_op_imm(5'd8, 3'b110, 5'd0, 12'h000), random_pc());
        end_test("x0 stays zero");

        $display("%0d tests passed, %0d tests failed, %0d checks failed",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/int_core.sv
`timescale 1ns/1ps
`default_nettype none

module int_core import rv_int_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_valid,
    input  wire instr_t   i_instr,
    input  wire addr_t    i_pc,
    output logic          o_valid,
    output logic          o_exception,
    output reg_idx_t      o_rd,
    output xlen_t         o_result
);

    dec_req_t  dec_req;
    exec_rsp_t exec_rsp;
    xlen_t     rs1_data;
    logic      wr_en;

    // Decode stage
    instr_decode i_instr_decode (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .o_req   (dec_req)
    );

    // Writeback only for legal results with a real target
    assign wr_en = exec_rsp.valid && !exec_rsp.exception && exec_rsp.rd != '0;

    reg_file i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .i_rd_idx  (dec_req.rs1),
        .o_rd_data (rs1_data),
        .i_wr_en   (wr_en),
        .i_wr_idx  (exec_rsp.rd),
        .i_wr_data (exec_rsp.result)
    );

    // Execute stage
    exec_int i_exec_int (
        .clk        (clk),
        .rst        (rst),
        .i_req      (dec_req),
        .i_rs1_data (rs1_data),
        .o_rsp      (exec_rsp)
    );

    assign o_valid     = exec_rsp.valid;
    assign o_exception = exec_rsp.exception;
    assign o_rd        = exec_rsp.rd;
    assign o_result    = exec_rsp.result;

endmodule

`default_nettype wire

//--- logic/exec_int.sv
`timescale 1ns/1ps
`default_nettype none

module exec_int import rv_int_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire dec_req_t i_req,
    input  wire xlen_t    i_rs1_data,
    output exec_rsp_t     o_rsp
);

    xlen_t  u_ext;      // U-immediate placed at bit 12 and sign extended
    xlen_t  i_ext;      // Sign extended I-immediate
    shamt_t shamt;
    logic   sra_sel;
    logic   slt_lt;
    logic   sltu_lt;
    xlen_t  result;
    logic   exception;

    assign u_ext   = {{(XLEN - U_IMM_W - 12){i_req.u_imm[U_IMM_W-1]}}, i_req.u_imm, 12'b0};
    assign i_ext   = {{(XLEN - I_IMM_W){i_req.i_imm[I_IMM_W-1]}}, i_req.i_imm};
    assign shamt   = i_req.i_imm[SHAMT_W-1:0];
    assign sra_sel = i_req.i_imm[SRA_SEL_BIT];

    assign slt_lt  = $signed(i_rs1_data) < $signed(i_ext);
    assign sltu_lt = i_rs1_data < i_ext;   // Unsigned compare after extension

    always_comb begin
        result    = '0;
        exception = 1'b0;

        case (i_req.opcode)
            OP_LUI: begin
                result = u_ext;
            end
            OP_AUIPC: begin
                result = i_req.pc + u_ext;
            end
            OP_OP_IMM: begin
                unique case (i_req.funct3)
                    F3_ADDI:  result = i_rs1_data + i_ext;
                    F3_SLTI:  result = {{(XLEN-1){1'b0}}, slt_lt};
                    F3_SLTIU: result = {{(XLEN-1){1'b0}}, sltu_lt};
                    F3_XORI:  result = i_rs1_data ^ i_ext;
                    F3_ORI:   result = i_rs1_data | i_ext;
                    F3_ANDI:  result = i_rs1_data & i_ext;
                    F3_SLLI: begin
                        // Upper six bits must be zero for a legal SLLI
                        exception = i_req.i_imm[I_IMM_W-1:SHAMT_W] != '0;
                        result    = i_rs1_data << shamt;
                    end
                    F3_SRXI: begin
                        // Only bit 30 may be set above the shift amount
                        exception = i_req.i_imm[I_IMM_W-1] ||
                                    i_req.i_imm[SRA_SEL_BIT-1:SHAMT_W] != '0;
                        if (sra_sel) begin
                            result = $signed(i_rs1_data) >>> shamt;
                        end else begin
                            result = i_rs1_data >> shamt;
                        end
                    end
                endcase
            end
            default: begin
                exception = 1'b1;   // Not handled by this slice
                result    = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rsp.valid <= 1'b0;
        end else begin
            o_rsp.valid <= i_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        o_rsp.exception <= exception;
        o_rsp.rd        <= i_req.rd;
        o_rsp.result    <= result;
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_int_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire reg_idx_t i_rd_idx,
    output xlen_t         o_rd_data,
    input  wire logic     i_wr_en,
    input  wire reg_idx_t i_wr_idx,
    input  wire xlen_t    i_wr_data
);

    xlen_t regs [1:(1 << REG_IDX_W) - 1];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < (1 << REG_IDX_W); i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != '0) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // Read port with same-cycle bypass of the write data
    always_comb begin
        if (i_rd_idx == '0) begin
            o_rd_data = '0;
        end else if (i_wr_en && i_wr_idx == i_rd_idx) begin
            o_rd_data = i_wr_data;   // Producer retiring this cycle
        end else begin
            o_rd_data = regs[i_rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import rv_int_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_valid,
    input  wire instr_t   i_instr,
    input  wire addr_t    i_pc,
    output dec_req_t      o_req
);

    dec_req_t fields;   // Combinational split of the incoming word

    always_comb begin
        fields        = '0;
        fields.valid  = i_valid;
        fields.pc     = i_pc;
        fields.opcode = opcode_e'(i_instr[OPCODE_LSB +: OPCODE_W]);
        fields.rd     = i_instr[RD_LSB +: REG_IDX_W];
        fields.funct3 = funct3_e'(i_instr[FUNCT3_LSB +: FUNCT3_W]);
        fields.rs1    = i_instr[RS1_LSB +: REG_IDX_W];

        // Immediates stay raw until execute sign extends them
        fields.i_imm  = i_instr[I_IMM_LSB +: I_IMM_W];
        fields.u_imm  = i_instr[U_IMM_LSB +: U_IMM_W];
    end

    // Decode valid follows the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            o_req.valid <= 1'b0;
        end else begin
            o_req.valid <= i_valid;
        end
    end

    // Payload holds its last value between strobes
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_req.pc     <= fields.pc;
            o_req.opcode <= fields.opcode;
            o_req.rd     <= fields.rd;
            o_req.funct3 <= fields.funct3;
            o_req.rs1    <= fields.rs1;
            o_req.i_imm  <= fields.i_imm;
            o_req.u_imm  <= fields.u_imm;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_int_pkg.sv
`default_nettype none

package rv_int_pkg;

    localparam int XLEN      = 64;
    localparam int ALEN      = 64;
    localparam int ILEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 5;
    localparam int FUNCT3_W  = 3;
    localparam int SHAMT_W   = 6;   // Enough for XLEN of 64

    // Field positions inside the raw instruction word
    localparam int OPCODE_LSB = 2;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int I_IMM_LSB  = 20;
    localparam int I_IMM_W    = 12;
    localparam int U_IMM_LSB  = 12;
    localparam int U_IMM_W    = 20;

    localparam int SRA_SEL_BIT = 10; // Instruction bit 30 within the I-immediate

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ALEN-1:0]      addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [ILEN-1:0]      instr_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;

    // Major opcode from instruction bits 6:2
    typedef enum logic [OPCODE_W-1:0] {
        OP_LOAD      = 5'b00000,
        OP_LOAD_FP   = 5'b00001,
        OP_CUSTOM_0  = 5'b00010,
        OP_MISC_MEM  = 5'b00011,
        OP_OP_IMM    = 5'b00100,
        OP_AUIPC     = 5'b00101,
        OP_OP_IMM_32 = 5'b00110,
        OP_STORE     = 5'b01000,
        OP_STORE_FP  = 5'b01001,
        OP_CUSTOM_1  = 5'b01010,
        OP_AMO       = 5'b01011,
        OP_OP        = 5'b01100,
        OP_LUI       = 5'b01101,
        OP_OP_32     = 5'b01110,
        OP_MADD      = 5'b10000,
        OP_MSUB      = 5'b10001,
        OP_NMSUB     = 5'b10010,
        OP_NMADD     = 5'b10011,
        OP_OP_FP     = 5'b10100,
        OP_CUSTOM_2  = 5'b10110,
        OP_BRANCH    = 5'b11000,
        OP_JALR      = 5'b11001,
        OP_JAL       = 5'b11011,
        OP_SYSTEM    = 5'b11100,
        OP_CUSTOM_3  = 5'b11110
    } opcode_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADDI  = 3'b000,
        F3_SLLI  = 3'b001,
        F3_SLTI  = 3'b010,
        F3_SLTIU = 3'b011,
        F3_XORI  = 3'b100,
        F3_SRXI  = 3'b101,   // SRLI or SRAI
        F3_ORI   = 3'b110,
        F3_ANDI  = 3'b111
    } funct3_e;

    typedef struct packed {
        logic                 valid;
        addr_t                pc;
        opcode_e              opcode;
        reg_idx_t             rd;
        funct3_e              funct3;
        reg_idx_t             rs1;
        logic [I_IMM_W-1:0]   i_imm;
        logic [U_IMM_W-1:0]   u_imm;
    } dec_req_t;

    typedef struct packed {
        logic     valid;
        logic     exception;
        reg_idx_t rd;
        xlen_t    result;
    } exec_rsp_t;

endpackage

`default_nettype wire
